/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  reg_idx_t;

    // Encodings follow funct3[1:0] of the CSR instructions.
    typedef enum logic [1:0] {
        csr_op_rw = 2'b01,
        csr_op_rs = 2'b10,
        csr_op_rc = 2'b11
    } csr_op_e;

    localparam logic [6:0] opcode_system = 7'b1110011;

    // User-level counters, read-only.
    localparam csr_addr_t csr_addr_cycle    = 12'hC00;
    localparam csr_addr_t csr_addr_time     = 12'hC01;
    localparam csr_addr_t csr_addr_instret  = 12'hC02;
    localparam csr_addr_t csr_addr_cycleh   = 12'hC80;
    localparam csr_addr_t csr_addr_timeh    = 12'hC81;
    localparam csr_addr_t csr_addr_instreth = 12'hC82;

    // Machine identification, read-only.
    localparam csr_addr_t csr_addr_mvendorid = 12'hF11;
    localparam csr_addr_t csr_addr_marchid   = 12'hF12;
    localparam csr_addr_t csr_addr_mimpid    = 12'hF13;
    localparam csr_addr_t csr_addr_mhartid   = 12'hF14;

    localparam csr_addr_t csr_addr_mscratch = 12'h340; // Machine read/write.

endpackage

`default_nettype wire

/* csr_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface csr_req_if
    import csr_pkg::*;
    ();

    logic      valid;
    logic      ready;
    csr_addr_t addr;
    csr_op_e   op;
    xlen_t     operand; // rs1 value or zero-extended immediate.
    logic      writes;
    reg_idx_t  rd;
    logic      illegal;

    modport source (
        output valid, addr, op, operand, writes, rd, illegal,
        input  ready
    );

    modport sink (
        input  valid, addr, op, operand, writes, rd, illegal,
        output ready
    );

endinterface

`default_nettype wire

/* csr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decoder
    import csr_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  instr_valid,
    output logic       instr_ready,
    input  wire xlen_t instr,
    input  wire xlen_t rs1_value,
    csr_req_if.source  req
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   src_field;
    logic       is_csr;
    csr_op_e    op_dec;
    xlen_t      operand_dec;
    logic       accept;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign src_field = instr[19:15];

    // funct3 0 and 4 are ECALL/EBREAK and friends, not CSR accesses.
    assign is_csr = (opcode == opcode_system) && (funct3[1:0] != 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b10:   op_dec = csr_op_rs;
            2'b11:   op_dec = csr_op_rc;
            default: op_dec = csr_op_rw;
        endcase
    end

    assign operand_dec = funct3[2] ? xlen_t'(src_field) : rs1_value;

    assign instr_ready = !req.valid || req.ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else if (accept) begin
            req.valid <= 1'b1;
        end else if (req.ready) begin
            req.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.addr    <= instr[31:20];
            req.op      <= op_dec;
            req.operand <= operand_dec;
            req.writes  <= is_csr && (op_dec == csr_op_rw || src_field != '0);
            req.rd      <= instr[11:7];
            req.illegal <= !is_csr;
        end
    end

    // A stalled request keeps its payload until the FIFO takes it.
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req.valid && !req.ready |=> req.valid &&
            $stable({req.addr, req.op, req.operand, req.writes, req.rd, req.illegal}))
        else $error("csr_decoder: request payload changed under back-pressure");

endmodule

`default_nettype wire

/* csr_req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_req_fifo
    import csr_pkg::*;
#(
    parameter int unsigned fifo_depth = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    csr_req_if.sink   in,
    csr_req_if.source out
);

    localparam int ptr_w   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int count_w = $clog2(fifo_depth + 1);

    csr_addr_t addr_mem    [fifo_depth];
    csr_op_e   op_mem      [fifo_depth];
    xlen_t     operand_mem [fifo_depth];
    logic      writes_mem  [fifo_depth];
    reg_idx_t  rd_mem      [fifo_depth];
    logic      illegal_mem [fifo_depth];

    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic               push;
    logic               pop;

    assign in.ready  = (count != count_w'(fifo_depth));
    assign out.valid = (count != '0);

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // Head entry straight from storage, so a write shows up one cycle later.
    assign out.addr    = addr_mem[rd_ptr];
    assign out.op      = op_mem[rd_ptr];
    assign out.operand = operand_mem[rd_ptr];
    assign out.writes  = writes_mem[rd_ptr];
    assign out.rd      = rd_mem[rd_ptr];
    assign out.illegal = illegal_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr]    <= in.addr;
            op_mem[wr_ptr]      <= in.op;
            operand_mem[wr_ptr] <= in.operand;
            writes_mem[wr_ptr]  <= in.writes;
            rd_mem[wr_ptr]      <= in.rd;
            illegal_mem[wr_ptr] <= in.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A full buffer has its write pointer wrapped onto the read pointer.
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (count <= count_w'(fifo_depth)) &&
            ((count != count_w'(fifo_depth)) || (wr_ptr == rd_ptr)))
        else $error("csr_req_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |-> (wr_ptr == rd_ptr))
        else $error("csr_req_fifo: pop while empty");

endmodule

`default_nettype wire

/* rv32_csrs.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_csrs
    import csr_pkg::*;
#(
    parameter xlen_t hart_id = '0
) (
    input  wire logic     clk,
    input  wire logic     rst,
    csr_req_if.sink       req,
    input  wire logic     instr_retired,
    output logic          rsp_valid,
    input  wire logic     rsp_ready,
    output reg_idx_t      rsp_rd,
    output xlen_t         rsp_value,
    output logic          rsp_illegal
);

    logic [63:0] cycle_q;
    logic [63:0] instret_q;
    xlen_t       mscratch_q;

    xlen_t read_value;
    xlen_t write_value;
    logic  known;
    logic  read_only;
    logic  illegal;
    logic  accept;

    always_comb begin
        known = 1'b1;
        case (req.addr)
            csr_addr_cycle,
            csr_addr_time:      read_value = cycle_q[31:0];
            csr_addr_cycleh,
            csr_addr_timeh:     read_value = cycle_q[63:32];
            csr_addr_instret:   read_value = instret_q[31:0];
            csr_addr_instreth:  read_value = instret_q[63:32];
            csr_addr_mvendorid,
            csr_addr_marchid,
            csr_addr_mimpid:    read_value = '0;
            csr_addr_mhartid:   read_value = hart_id;
            csr_addr_mscratch:  read_value = mscratch_q;
            default: begin
                read_value = '0;
                known      = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (req.op)
            csr_op_rs: write_value = read_value | req.operand;
            csr_op_rc: write_value = read_value & ~req.operand;
            default:   write_value = req.operand;
        endcase
    end

    assign read_only = (req.addr[11:10] == 2'b11);
    assign illegal   = req.illegal || !known || (req.writes && read_only);

    assign req.ready = !rsp_valid || rsp_ready;
    assign accept    = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q   <= cycle_q + 64'd1;
            instret_q <= instret_q + 64'(instr_retired);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch_q <= '0;
        end else if (accept && !illegal && req.writes && req.addr == csr_addr_mscratch) begin
            mscratch_q <= write_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_rd      <= req.rd;
            rsp_value   <= illegal ? '0 : read_value; // Old value of the CSR.
            rsp_illegal <= illegal;
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid &&
            $stable({rsp_rd, rsp_value, rsp_illegal}))
        else $error("rv32_csrs: response changed while stalled");

endmodule

`default_nettype wire

/* csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_top
    import csr_pkg::*;
#(
    parameter int unsigned fifo_depth = 4,
    parameter xlen_t       hart_id    = '0
) (
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     instr_valid,
    output logic          instr_ready,
    input  wire xlen_t    instr,
    input  wire xlen_t    rs1_value,

    input  wire logic     instr_retired, // From writeback.

    output logic          rsp_valid,
    input  wire logic     rsp_ready,
    output reg_idx_t      rsp_rd,
    output xlen_t         rsp_value,
    output logic          rsp_illegal
);

    csr_req_if dec_req ();
    csr_req_if csr_req ();

    csr_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .req         (dec_req.source)
    );

    csr_req_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk (clk),
        .rst (rst),
        .in  (dec_req.sink),
        .out (csr_req.source)
    );

    rv32_csrs #(
        .hart_id (hart_id)
    ) u_csrs (
        .clk           (clk),
        .rst           (rst),
        .req           (csr_req.sink),
        .instr_retired (instr_retired),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_rd        (rsp_rd),
        .rsp_value     (rsp_value),
        .rsp_illegal   (rsp_illegal)
    );

endmodule

`default_nettype wire

/* tb_csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top
    import csr_pkg::*;
();

    typedef struct packed {
        reg_idx_t rd;
        logic     illegal;
        logic     check_value; // Counter reads are checked separately.
        xlen_t    value;
    } expect_t;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    logic     instr_ready;
    xlen_t    instr;
    xlen_t    rs1_value;
    logic     instr_retired;
    logic     rsp_valid;
    logic     rsp_ready;
    reg_idx_t rsp_rd;
    xlen_t    rsp_value;
    logic     rsp_illegal;

    expect_t     exp_q [$];
    xlen_t       model_mscratch;
    logic [31:0] lcg_state;
    xlen_t       last_value;
    int          mismatches;
    int          timeouts;
    int          responses;

    csr_top #(
        .fifo_depth (4),
        .hart_id    (32'd5)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .instr         (instr),
        .rs1_value     (rs1_value),
        .instr_retired (instr_retired),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_rd        (rsp_rd),
        .rsp_value     (rsp_value),
        .rsp_illegal   (rsp_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic xlen_t csr_instr(csr_addr_t addr, logic [4:0] src,
                                        logic [2:0] funct3, reg_idx_t rd);
        return {addr, src, funct3, rd, 7'b1110011};
    endfunction

    function automatic csr_addr_t pick_addr(logic [2:0] sel);
        case (sel)
            3'd3:    return 12'hC00;
            3'd4:    return 12'hC82;
            3'd5:    return 12'hF14;
            3'd6:    return 12'hF11;
            3'd7:    return 12'h7C0; // Not implemented.
            default: return 12'h340;
        endcase
    endfunction

    // Reference model of one instruction, tracks mscratch.
    function automatic expect_t predict(xlen_t word, xlen_t rs1);
        expect_t    e;
        logic [2:0] f3;
        xlen_t      operand;
        xlen_t      old;
        logic       writes;
        logic       known;
        f3            = word[14:12];
        e.rd          = word[11:7];
        e.illegal     = 1'b0;
        e.check_value = 1'b1;
        e.value       = '0;
        operand       = f3[2] ? {27'd0, word[19:15]} : rs1;
        writes        = (f3[1:0] == 2'b01) || (word[19:15] != 5'd0);
        known         = 1'b1;
        old           = '0;
        case (word[31:20])
            12'hC00, 12'hC01, 12'hC02,
            12'hC80, 12'hC81, 12'hC82: e.check_value = 1'b0;
            12'hF11, 12'hF12, 12'hF13: old = '0;
            12'hF14:                   old = 32'd5;
            12'h340:                   old = model_mscratch;
            default:                   known = 1'b0;
        endcase
        if (word[6:0] != 7'b1110011 || f3[1:0] == 2'b00 || !known ||
                (writes && word[31:30] == 2'b11)) begin
            e.illegal     = 1'b1;
            e.check_value = 1'b1;
        end else begin
            e.value = old;
            if (writes && word[31:20] == 12'h340) begin
                case (f3[1:0])
                    2'b01:   model_mscratch = operand;
                    2'b10:   model_mscratch = old | operand;
                    default: model_mscratch = old & ~operand;
                endcase
            end
        end
        return e;
    endfunction

    task automatic send(xlen_t word, xlen_t rs1);
        int waited;
        waited = 0;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        rs1_value   = rs1;
        while (!instr_ready && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (!instr_ready) begin
            $display("timeout at %0t: instruction was never accepted", $time);
            timeouts++;
        end else begin
            @(posedge clk);
            exp_q.push_back(predict(word, rs1));
        end
    endtask

    task automatic idle();
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t: %0d responses never arrived", $time, exp_q.size());
            timeouts++;
        end
    endtask

    // Returns once rsp_valid has been low for four cycles in a row.
    task automatic wait_quiet();
        int waited;
        int low;
        waited = 0;
        low    = 0;
        while (low < 4 && waited < 2000) begin
            @(posedge clk);
            low = rsp_valid ? 0 : low + 1;
            waited++;
        end
        if (low < 4) begin
            $display("timeout at %0t: response channel never went quiet", $time);
            timeouts++;
        end
    endtask

    task automatic read_csr(csr_addr_t addr);
        send(csr_instr(addr, 5'd0, 3'b010, 5'd9), '0);
        idle();
        wait_drain();
    endtask

    task automatic check_response();
        expect_t e;
        assert (exp_q.size() > 0) else begin
            timeouts++;
            $display("unexpected response at %0t with nothing outstanding", $time);
        end
        if (exp_q.size() > 0) begin
            e          = exp_q.pop_front();
            last_value = rsp_value;
            responses++;
            assert (rsp_rd == e.rd && rsp_illegal == e.illegal) else begin
                mismatches++;
                $display("MISMATCH at %0t: rd %0d illegal %0b, expected rd %0d illegal %0b",
                         $time, rsp_rd, rsp_illegal, e.rd, e.illegal);
            end
            assert (!e.check_value || rsp_value == e.value) else begin
                mismatches++;
                $display("MISMATCH at %0t: value %h, expected %h", $time, rsp_value, e.value);
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (!rst && rsp_valid && rsp_ready) begin
                check_response();
            end
        end
    end

    initial begin
        logic [31:0] r;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            r         = next_rand();
            rsp_ready = (r[17:16] != 2'b00);
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_value) &&
            $stable(rsp_rd) && $stable(rsp_illegal))
        else begin
            mismatches++;
            $display("MISMATCH at %0t: response changed while stalled", $time);
        end

    initial begin
        xlen_t       v0;
        xlen_t       c0;
        logic [31:0] r;
        logic [31:0] word;
        lcg_state      = 32'd29970;
        model_mscratch = '0;
        mismatches     = 0;
        timeouts       = 0;
        responses      = 0;
        last_value     = '0;
        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr          = '0;
        rs1_value      = '0;
        instr_retired  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Not CSR accesses.
        send(32'h0000_0013, '0);
        send(csr_instr(12'h340, 5'd1, 3'b000, 5'd3), 32'd7);
        send(csr_instr(12'h340, 5'd1, 3'b100, 5'd4), 32'd7);
        // mscratch through every operation and source.
        send(csr_instr(12'h340, 5'd1, 3'b001, 5'd1), 32'hA5A5_0F0F);
        send(csr_instr(12'h340, 5'd2, 3'b010, 5'd2), 32'h0000_F0F0);
        send(csr_instr(12'h340, 5'd3, 3'b011, 5'd5), 32'hA000_0000);
        send(csr_instr(12'h340, 5'h1F, 3'b101, 5'd6), 32'hFFFF_FFFF);
        send(csr_instr(12'h340, 5'h10, 3'b110, 5'd7), '0);
        send(csr_instr(12'h340, 5'h03, 3'b111, 5'd8), '0);
        send(csr_instr(12'h340, 5'd0, 3'b010, 5'd10), 32'h1234_5678);
        // Read-only and unknown addresses.
        send(csr_instr(12'hC00, 5'd1, 3'b001, 5'd11), 32'd99);
        send(csr_instr(12'hF14, 5'd1, 3'b001, 5'd12), 32'd99);
        send(csr_instr(12'hF11, 5'd4, 3'b110, 5'd13), '0);
        send(csr_instr(12'hC00, 5'd0, 3'b010, 5'd14), 32'd1);
        send(csr_instr(12'hC00, 5'd0, 3'b011, 5'd15), 32'd1);
        send(csr_instr(12'hC80, 5'd0, 3'b110, 5'd16), '0);
        send(csr_instr(12'h7C0, 5'd0, 3'b010, 5'd17), '0);
        // Identification registers.
        send(csr_instr(12'hF11, 5'd0, 3'b010, 5'd18), '0);
        send(csr_instr(12'hF12, 5'd0, 3'b010, 5'd19), '0);
        send(csr_instr(12'hF13, 5'd0, 3'b010, 5'd20), '0);
        send(csr_instr(12'hF14, 5'd0, 3'b010, 5'd21), '0);
        idle();
        wait_drain();

        // Retire count over an idle stretch.
        read_csr(12'hC02);
        v0 = last_value;
        repeat (7) begin
            @(negedge clk);
            instr_retired = 1'b1;
            @(negedge clk);
            instr_retired = 1'b0;
        end
        wait_quiet();
        read_csr(12'hC02);
        assert (last_value == v0 + 32'd7) else begin
            mismatches++;
            $display("MISMATCH at %0t: instret %0d, expected %0d", $time, last_value, v0 + 32'd7);
        end
        read_csr(12'hC82);
        assert (last_value == '0) else begin
            mismatches++;
            $display("MISMATCH at %0t: instreth %h, expected zero", $time, last_value);
        end
        read_csr(12'hC00);
        c0 = last_value;
        read_csr(12'hC00);
        assert (last_value > c0) else begin
            mismatches++;
            $display("MISMATCH at %0t: cycle %0d not above %0d", $time, last_value, c0);
        end

        // Random traffic against a stalling response channel.
        repeat (80) begin
            r    = next_rand();
            word = csr_instr(pick_addr(r[2:0]), r[10:6], r[5:3], r[15:11]);
            if (r[20:18] == 3'd0) begin
                word[6:0] = 7'b0110011;
            end
            send(word, next_rand());
        end
        idle();
        wait_drain();
        repeat (5) @(posedge clk);

        $display("checks done: %0d responses, %0d mismatches, %0d timeouts",
                 responses, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_top.f */
csr_pkg.sv
csr_req_if.sv
csr_decoder.sv
csr_req_fifo.sv
rv32_csrs.sv
csr_top.sv
tb_csr_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CSR testbench with Verilator, runs it and judges the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_csr_top \
    -f csr_top.f \
    --Mdir obj_dir -o sim_csr
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_csr > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "tests failed" "$LOG"; then
    exit 1
fi

exit 0
